// File: mips_cpu_harvard.f
source/mips_pkg.sv
source/mips_ctrl_if.sv
source/mips_decoder.sv
source/mips_alu.sv
source/mips_register_file.sv
source/mips_datapath.sv
source/mips_cpu_harvard.sv
verification/mips_checker.sv
verification/mips_cpu_harvard_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide pass or fail from the log
rm -rf obj_dir sim.log
verilator --binary --timing -f mips_cpu_harvard.f --top-module mips_cpu_harvard_tb -o sim \
	&& ./obj_dir/sim > sim.log \
	|| { echo "build or run failed"; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: source/mips_alu.sv
`timescale 1ns/1ns
`default_nettype none

module mips_alu (
	input  mips_pkg::alu_op_t op,
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	output mips_pkg::word_t   result,
	output logic              zero
);

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	assign shamt       = a[4:0];                 // Shift distance from operand A
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD:  result = a + b;
			mips_pkg::ALU_SUB:  result = a - b;
			mips_pkg::ALU_AND:  result = a & b;
			mips_pkg::ALU_OR:   result = a | b;
			mips_pkg::ALU_XOR:  result = a ^ b;
			mips_pkg::ALU_NOR:  result = ~(a | b);
			mips_pkg::ALU_SLT:  result = {31'b0, lt_signed};
			mips_pkg::ALU_SLTU: result = {31'b0, lt_unsigned};
			mips_pkg::ALU_SLL:  result = b << shamt;
			mips_pkg::ALU_SRL:  result = b >> shamt;
			mips_pkg::ALU_SRA:  result = $unsigned($signed(b) >>> shamt); // Sign fill
			mips_pkg::ALU_LUI:  result = {b[15:0], 16'h0000};
			default:            result = '0;
		endcase
	end

	assign zero = (result == '0); // Equal operands after SUB

endmodule

`default_nettype wire

// File: source/mips_cpu_harvard.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard #(
	parameter mips_pkg::word_t reset_vector = mips_pkg::reset_vector_default
) (
	input  logic            clk,
	input  logic            reset,
	output logic            active,
	output mips_pkg::word_t register_v0,
	input  logic            clk_enable,
	output mips_pkg::word_t instr_address,  // Current PC
	input  mips_pkg::word_t instr_readdata, // Same-cycle fetch
	output mips_pkg::word_t data_address,
	output logic            data_write,
	output logic            data_read,
	output mips_pkg::word_t data_writedata,
	input  mips_pkg::word_t data_readdata   // Same-cycle load data
);

	mips_ctrl_if ctrl_if ();

	mips_decoder decoder_i (
		.instr (instr_readdata),
		.ctrl  (ctrl_if)
	);

	mips_datapath #(
		.reset_vector (reset_vector)
	) datapath_i (
		.clk            (clk),
		.reset          (reset),
		.clk_enable     (clk_enable),
		.ctrl           (ctrl_if),
		.instr          (instr_readdata),
		.pc             (instr_address),
		.active         (active),
		.data_readdata  (data_readdata),
		.data_address   (data_address),
		.data_writedata (data_writedata),
		.data_write     (data_write),
		.data_read      (data_read),
		.register_v0    (register_v0)
	);

endmodule

`default_nettype wire

// File: source/mips_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface mips_ctrl_if;

	mips_pkg::alu_op_t alu_op;
	logic alu_src_imm;        // Operand B from immediate
	logic imm_zero_ext;       // Logical immediates
	logic shift_by_shamt;     // Operand A from shamt field
	logic reg_write;
	logic [1:0] dest_sel;     // 0 rt, 1 rd, 2 r31
	mips_pkg::wb_sel_t wb_sel;
	mips_pkg::pc_sel_t pc_sel;
	logic branch_ne;          // BNE sense
	logic mem_write;
	logic mem_read;

	modport decoder (
		output alu_op, alu_src_imm, imm_zero_ext, shift_by_shamt, reg_write,
		output dest_sel, wb_sel, pc_sel, branch_ne, mem_write, mem_read
	);

	modport datapath (
		input alu_op, alu_src_imm, imm_zero_ext, shift_by_shamt, reg_write,
		input dest_sel, wb_sel, pc_sel, branch_ne, mem_write, mem_read
	);

endinterface

`default_nettype wire

// File: source/mips_datapath.sv
`timescale 1ns/1ns
`default_nettype none

module mips_datapath #(
	parameter mips_pkg::word_t reset_vector = mips_pkg::reset_vector_default
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            clk_enable,
	mips_ctrl_if.datapath   ctrl,
	input  mips_pkg::word_t instr,
	output mips_pkg::word_t pc,
	output logic            active,
	input  mips_pkg::word_t data_readdata,
	output mips_pkg::word_t data_address,
	output mips_pkg::word_t data_writedata,
	output logic            data_write,
	output logic            data_read,
	output mips_pkg::word_t register_v0
);

	mips_pkg::word_t pc_next;
	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t pc_plus8;
	mips_pkg::word_t branch_target;
	mips_pkg::word_t jump_target;
	mips_pkg::word_t imm_ext;
	mips_pkg::word_t rs_data;
	mips_pkg::word_t rt_data;
	mips_pkg::word_t alu_a;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_result;
	mips_pkg::word_t wb_data;
	logic [4:0]      write_addr;
	logic            alu_zero;
	logic            branch_taken;
	logic            retire;

	assign retire = clk_enable && active; // Instruction completes this edge

	// Immediate extension
	assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, instr[15:0]}
		: {{16{instr[15]}}, instr[15:0]};

	// Next PC candidates
	assign pc_plus4      = pc + 32'd4;
	assign pc_plus8      = pc + 32'd8;                             // Link value, MIPS convention
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign jump_target   = {pc_plus4[31:28], instr[25:0], 2'b00}; // Same 256 MB segment
	assign branch_taken  = alu_zero ^ ctrl.branch_ne;             // BNE inverts sense

	always_comb begin
		case (ctrl.pc_sel)
			mips_pkg::PC_BRANCH: pc_next = branch_taken ? branch_target : pc_plus4;
			mips_pkg::PC_JUMP:   pc_next = jump_target;
			mips_pkg::PC_REG:    pc_next = rs_data;
			default:             pc_next = pc_plus4;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc     <= reset_vector;
			active <= 1'b1;
		end else if (retire) begin
			pc     <= pc_next;
			active <= (pc_next != '0); // Jump to 0 halts
		end
	end

	// Operand selection
	assign alu_a = ctrl.shift_by_shamt ? {27'b0, instr[10:6]} : rs_data;
	assign alu_b = ctrl.alu_src_imm ? imm_ext : rt_data;

	always_comb begin
		case (ctrl.dest_sel)
			2'd1:    write_addr = instr[15:11]; // rd
			2'd2:    write_addr = 5'd31;        // Link register
			default: write_addr = instr[20:16]; // rt
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			mips_pkg::WB_MEM:  wb_data = data_readdata;
			mips_pkg::WB_LINK: wb_data = pc_plus8;
			default:           wb_data = alu_result;
		endcase
	end

	mips_register_file register_file_i (
		.clk          (clk),
		.reset        (reset),
		.write_enable (ctrl.reg_write && retire),
		.read_addr_a  (instr[25:21]),
		.read_addr_b  (instr[20:16]),
		.write_addr   (write_addr),
		.write_data   (wb_data),
		.read_data_a  (rs_data),
		.read_data_b  (rt_data),
		.reg_v0       (register_v0)
	);

	mips_alu alu_i (
		.op     (ctrl.alu_op),
		.a      (alu_a),
		.b      (alu_b),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// Data memory side
	assign data_address   = alu_result;
	assign data_writedata = rt_data;
	assign data_write     = ctrl.mem_write && retire; // Quiet while stalled or halted
	assign data_read      = ctrl.mem_read && retire;

endmodule

`default_nettype wire

// File: source/mips_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module mips_decoder (
	input  mips_pkg::word_t instr,
	mips_ctrl_if.decoder    ctrl
);

	mips_pkg::opcode_t opcode;
	mips_pkg::funct_t  funct;

	assign opcode = mips_pkg::opcode_t'(instr[31:26]); // Unlisted codes fall to default
	assign funct  = mips_pkg::funct_t'(instr[5:0]);

	always_comb begin
		ctrl.alu_op         = mips_pkg::ALU_ADD; // Defaults give a no-op
		ctrl.alu_src_imm    = 1'b0;
		ctrl.imm_zero_ext   = 1'b0;
		ctrl.shift_by_shamt = 1'b0;
		ctrl.reg_write      = 1'b0;
		ctrl.dest_sel       = 2'd0;             // rt
		ctrl.wb_sel         = mips_pkg::WB_ALU;
		ctrl.pc_sel         = mips_pkg::PC_SEQ;
		ctrl.branch_ne      = 1'b0;
		ctrl.mem_write      = 1'b0;
		ctrl.mem_read       = 1'b0;
		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				ctrl.dest_sel  = 2'd1; // rd
				ctrl.reg_write = 1'b1;
				case (funct)
					mips_pkg::F_SLL: begin
						ctrl.alu_op         = mips_pkg::ALU_SLL;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_pkg::F_SRL: begin
						ctrl.alu_op         = mips_pkg::ALU_SRL;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_pkg::F_SRA: begin
						ctrl.alu_op         = mips_pkg::ALU_SRA;
						ctrl.shift_by_shamt = 1'b1;
					end
					mips_pkg::F_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.pc_sel    = mips_pkg::PC_REG; // Target from rs
					end
					mips_pkg::F_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::F_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::F_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::F_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::F_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::F_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::F_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					default:          ctrl.reg_write = 1'b0; // Unsupported funct
				endcase
			end
			mips_pkg::OP_J: ctrl.pc_sel = mips_pkg::PC_JUMP;
			mips_pkg::OP_JAL: begin
				ctrl.pc_sel    = mips_pkg::PC_JUMP;
				ctrl.reg_write = 1'b1;
				ctrl.dest_sel  = 2'd2;              // r31
				ctrl.wb_sel    = mips_pkg::WB_LINK;
			end
			mips_pkg::OP_BEQ, mips_pkg::OP_BNE: begin
				ctrl.alu_op    = mips_pkg::ALU_SUB; // Compare via zero flag
				ctrl.pc_sel    = mips_pkg::PC_BRANCH;
				ctrl.branch_ne = (opcode == mips_pkg::OP_BNE);
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU,
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				ctrl.alu_src_imm  = 1'b1;
				ctrl.reg_write    = 1'b1;
				ctrl.imm_zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI)
					|| (opcode == mips_pkg::OP_XORI); // Logical ops zero extend
				case (opcode)
					mips_pkg::OP_SLTI:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU; // Still sign extended
					mips_pkg::OP_ANDI:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::OP_LUI:   ctrl.alu_op = mips_pkg::ALU_LUI;
					default:            ctrl.alu_op = mips_pkg::ALU_ADD; // ADDIU
				endcase
			end
			mips_pkg::OP_LW: begin
				ctrl.alu_src_imm = 1'b1; // Base plus offset
				ctrl.reg_write   = 1'b1;
				ctrl.wb_sel      = mips_pkg::WB_MEM;
				ctrl.mem_read    = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			default: ; // Unknown opcode stays a no-op
		endcase
	end

endmodule

`default_nettype wire

// File: source/mips_pkg.sv
`default_nettype none

package mips_pkg;

	typedef logic [31:0] word_t; // Data and address word

	// Primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000, // R-type, decoded further by funct
		OP_J       = 6'b000010,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDIU   = 6'b001001,
		OP_SLTI    = 6'b001010,
		OP_SLTIU   = 6'b001011,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_XORI    = 6'b001110,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_t;

	// Function field for SPECIAL, instr[5:0]
	typedef enum logic [5:0] {
		F_SLL  = 6'b000000,
		F_SRL  = 6'b000010,
		F_SRA  = 6'b000011,
		F_JR   = 6'b001000,
		F_ADDU = 6'b100001,
		F_SUBU = 6'b100011,
		F_AND  = 6'b100100,
		F_OR   = 6'b100101,
		F_XOR  = 6'b100110,
		F_SLT  = 6'b101010,
		F_SLTU = 6'b101011
	} funct_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
	} alu_op_t;

	typedef enum logic [1:0] {
		PC_SEQ,    // PC+4
		PC_BRANCH, // PC+4 plus offset, if condition holds
		PC_JUMP,   // 26-bit target in current segment
		PC_REG     // Value of rs
	} pc_sel_t;

	typedef enum logic [1:0] {
		WB_ALU,  // ALU result
		WB_MEM,  // Load data
		WB_LINK  // Return address
	} wb_sel_t;

	localparam word_t reset_vector_default = 32'hBFC0_0000; // Boot ROM base

endpackage

`default_nettype wire

// File: source/mips_register_file.sv
`timescale 1ns/1ns
`default_nettype none

module mips_register_file (
	input  logic            clk,
	input  logic            reset,
	input  logic            write_enable,
	input  logic [4:0]      read_addr_a,
	input  logic [4:0]      read_addr_b,
	input  logic [4:0]      write_addr,
	input  mips_pkg::word_t write_data,
	output mips_pkg::word_t read_data_a,
	output mips_pkg::word_t read_data_b,
	output mips_pkg::word_t reg_v0
);

	mips_pkg::word_t regs [32];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write_enable && write_addr != 5'd0) begin // r0 never written
			regs[write_addr] <= write_data;
		end
	end

	assign read_data_a = (read_addr_a == 5'd0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == 5'd0) ? '0 : regs[read_addr_b];
	assign reg_v0      = regs[2]; // Result register for debug port

endmodule

`default_nettype wire

// File: verification/mips_checker.sv
`timescale 1ns/1ns
`default_nettype none

module mips_checker #(
	parameter mips_pkg::word_t reset_vector = mips_pkg::reset_vector_default
) (
	input logic            clk,
	input logic            reset,
	input logic            clk_enable,
	input logic            active,
	input mips_pkg::word_t register_v0,
	input mips_pkg::word_t instr_address,
	input mips_pkg::word_t instr_readdata,
	input mips_pkg::word_t data_address,
	input logic            data_write,
	input logic            data_read,
	input mips_pkg::word_t data_writedata,
	input mips_pkg::word_t data_readdata
);

	int error_count = 0;

	mips_pkg::word_t m_pc;             // Model state
	mips_pkg::word_t m_regs [32];
	mips_pkg::word_t m_mem [mips_pkg::word_t]; // Words written by the model
	logic            m_active;
	logic            exp_write;         // Expected data port for this step
	logic            exp_read;
	mips_pkg::word_t exp_addr;
	mips_pkg::word_t exp_wdata;
	logic            prev_reset = 1'b1;
	logic            was_stall = 1'b0;
	mips_pkg::word_t last_pc;
	mips_pkg::word_t last_v0;

	task automatic report_value(input string name, input mips_pkg::word_t expected,
		input mips_pkg::word_t actual);
		if (expected !== actual) begin
			$display("error %s expected %h got %h", name, expected, actual);
			error_count++;
		end
	endtask

	// Executes one instruction on the model
	function automatic void step_model(input mips_pkg::word_t instr,
		input mips_pkg::word_t load_data);
		mips_pkg::opcode_t op;
		mips_pkg::funct_t  fn;
		logic [4:0]        rs;
		logic [4:0]        rt;
		logic [4:0]        dst;
		logic [4:0]        sh;
		mips_pkg::word_t   a;
		mips_pkg::word_t   b;
		mips_pkg::word_t   simm;
		mips_pkg::word_t   zimm;
		mips_pkg::word_t   res;
		mips_pkg::word_t   next_pc;
		logic              wr;
		op = mips_pkg::opcode_t'(instr[31:26]);
		fn = mips_pkg::funct_t'(instr[5:0]);
		rs = instr[25:21];
		rt = instr[20:16];
		sh = instr[10:6];
		a = m_regs[rs];
		b = m_regs[rt];
		simm = {{16{instr[15]}}, instr[15:0]};
		zimm = {16'h0000, instr[15:0]};
		next_pc = m_pc + 32'd4; // No delay slot
		dst = rt;
		wr = 1'b0;
		res = '0;
		exp_write = 1'b0;
		exp_read = 1'b0;
		case (op)
			mips_pkg::OP_SPECIAL: begin
				dst = instr[15:11];
				wr = 1'b1;
				case (fn)
					mips_pkg::F_SLL:  res = b << sh;
					mips_pkg::F_SRL:  res = b >> sh;
					mips_pkg::F_SRA:  res = mips_pkg::word_t'($signed(b) >>> sh);
					mips_pkg::F_ADDU: res = a + b;
					mips_pkg::F_SUBU: res = a - b;
					mips_pkg::F_AND:  res = a & b;
					mips_pkg::F_OR:   res = a | b;
					mips_pkg::F_XOR:  res = a ^ b;
					mips_pkg::F_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::F_SLTU: res = (a < b) ? 32'd1 : 32'd0;
					mips_pkg::F_JR: begin
						wr = 1'b0;
						next_pc = a;
					end
					default: wr = 1'b0;
				endcase
			end
			mips_pkg::OP_J: next_pc = {m_pc[31:28], instr[25:0], 2'b00};
			mips_pkg::OP_JAL: begin
				next_pc = {m_pc[31:28], instr[25:0], 2'b00};
				wr = 1'b1;
				dst = 5'd31;
				res = m_pc + 32'd8; // Link skips a slot that is not there
			end
			mips_pkg::OP_BEQ: if (a == b) next_pc = m_pc + 32'd4 + (simm << 2);
			mips_pkg::OP_BNE: if (a != b) next_pc = m_pc + 32'd4 + (simm << 2);
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_SLTIU, mips_pkg::OP_ANDI,
			mips_pkg::OP_ORI, mips_pkg::OP_XORI, mips_pkg::OP_LUI: begin
				wr = 1'b1;
				case (op)
					mips_pkg::OP_ADDIU: res = a + simm;
					mips_pkg::OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
					mips_pkg::OP_SLTIU: res = (a < simm) ? 32'd1 : 32'd0;
					mips_pkg::OP_ANDI:  res = a & zimm;
					mips_pkg::OP_ORI:   res = a | zimm;
					mips_pkg::OP_XORI:  res = a ^ zimm;
					mips_pkg::OP_LUI:   res = {instr[15:0], 16'h0000};
					default: ;
				endcase
			end
			mips_pkg::OP_LW: begin
				wr = 1'b1;
				exp_read = 1'b1;
				exp_addr = a + simm;
				res = m_mem.exists(exp_addr) ? m_mem[exp_addr] : load_data; // Unwritten words from memory
			end
			mips_pkg::OP_SW: begin
				exp_write = 1'b1;
				exp_addr = a + simm;
				exp_wdata = b;
				m_mem[a + simm] = b;
			end
			default: ; // No-op
		endcase
		if (wr && dst != 5'd0) m_regs[dst] = res;
		m_pc = next_pc;
		m_active = (next_pc != '0); // Jump to 0 halts
	endfunction

	always @(posedge clk) begin
		if (reset) begin
			m_pc = reset_vector;
			m_active = 1'b1;
			for (int i = 0; i < 32; i++) m_regs[i] = '0;
			m_mem.delete();
			prev_reset = 1'b1;
			was_stall = 1'b0;
		end else begin
			if (prev_reset) begin // First edge out of reset
				report_value("instr_address", reset_vector, instr_address);
				report_value("active", 32'd1, {31'b0, active});
				report_value("data_write", 32'd0, {31'b0, data_write});
			end
			report_value("active", {31'b0, m_active}, {31'b0, active});
			if (clk_enable && m_active) begin
				report_value("instr_address", m_pc, instr_address);
				step_model(instr_readdata, data_readdata);
				report_value("data_write", {31'b0, exp_write}, {31'b0, data_write});
				report_value("data_read", {31'b0, exp_read}, {31'b0, data_read});
				if (exp_write || exp_read) begin
					report_value("data_address", exp_addr, data_address);
				end
				if (exp_write) begin
					report_value("data_writedata", exp_wdata, data_writedata);
				end
			end else if (data_write || data_read) begin
				$display("data strobe asserted while stalled or halted");
				error_count++;
			end
			if (was_stall) begin // Nothing may move across a stalled edge
				report_value("instr_address", last_pc, instr_address);
				report_value("register_v0", last_v0, register_v0);
			end
			if (!m_active && !active) report_value("register_v0", m_regs[2], register_v0);
			was_stall = !clk_enable;
			last_pc = instr_address;
			last_v0 = register_v0;
			prev_reset = 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: verification/mips_cpu_harvard_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mips_cpu_harvard_tb;

	localparam mips_pkg::word_t base = mips_pkg::reset_vector_default;

	logic            clk;
	logic            reset;
	logic            clk_enable;
	logic            active;
	mips_pkg::word_t register_v0;
	mips_pkg::word_t instr_address;
	mips_pkg::word_t instr_readdata;
	mips_pkg::word_t data_address;
	logic            data_write;
	logic            data_read;
	mips_pkg::word_t data_writedata;
	mips_pkg::word_t data_readdata;

	mips_pkg::word_t imem [128];  // Program at the reset vector
	mips_pkg::word_t dmem [256];  // Aliased by address bits 9:2
	mips_pkg::word_t instr_offset; // Word index from the reset vector
	mips_pkg::word_t lfsr_state = 32'd66;
	int              n = 0;       // Next program slot
	int              st_off = 'h40;
	int              timeouts = 0;
	int              cycles;

	// Galois LFSR stepped once per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA300_0000 : lfsr_state >> 1;
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	function automatic mips_pkg::word_t enc_r(input mips_pkg::funct_t f, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'b000000, rs, rt, rd, sh, f};
	endfunction

	function automatic mips_pkg::word_t enc_i(input mips_pkg::opcode_t op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic mips_pkg::word_t enc_j(input mips_pkg::opcode_t op,
		input mips_pkg::word_t target);
		return {op, target[27:2]};
	endfunction

	task automatic emit(input mips_pkg::word_t word);
		imem[n] = word;
		n++;
	endtask

	task automatic store_result(input mips_pkg::word_t word); // Op into r10, store, fold into v0
		emit(word);
		emit(enc_i(mips_pkg::OP_SW, 5'd16, 5'd10, 16'(st_off)));
		emit(enc_r(mips_pkg::F_ADDU, 5'd2, 5'd10, 5'd2, 5'd0));
		st_off += 4;
	endtask

	assign instr_offset   = (instr_address - base) >> 2;
	assign instr_readdata = instr_offset < 32'd128 ? imem[instr_offset[6:0]] : '0; // NOP outside
	assign data_readdata  = dmem[data_address[9:2]]; // Same-cycle read

	always @(posedge clk) begin
		if (data_write && clk_enable) dmem[data_address[9:2]] <= data_writedata;
		if (!reset) clk_enable <= (random_bits(2) != 32'd0); // Stall about one in four
	end

	mips_cpu_harvard #(.reset_vector(base)) mips_cpu_harvard_i (.*);

	mips_checker #(.reset_vector(base)) checker_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		reset = 1'b1;
		clk_enable = 1'b0;
		for (int i = 0; i < 128; i++) imem[i] = '0;
		for (int i = 0; i < 256; i++) dmem[i] = random_bits(32);
		emit(enc_i(mips_pkg::OP_ORI, 5'd0, 5'd16, 16'h1000)); // Data base
		emit(enc_i(mips_pkg::OP_LW, 5'd16, 5'd8, 16'h0000));
		emit(enc_i(mips_pkg::OP_LW, 5'd16, 5'd9, 16'h0004));
		emit(enc_i(mips_pkg::OP_LW, 5'd16, 5'd12, 16'h0008));
		store_result(enc_r(mips_pkg::F_ADDU, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_SUBU, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_AND, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_OR, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_XOR, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_SLT, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_SLTU, 5'd8, 5'd9, 5'd10, 5'd0));
		store_result(enc_r(mips_pkg::F_SLL, 5'd0, 5'd8, 5'd10, 5'd5));
		store_result(enc_r(mips_pkg::F_SRL, 5'd0, 5'd9, 5'd10, 5'd7));
		store_result(enc_r(mips_pkg::F_SRA, 5'd0, 5'd8, 5'd10, 5'd13));
		store_result(enc_r(mips_pkg::F_SRA, 5'd0, 5'd12, 5'd10, 5'd31));
		store_result(enc_i(mips_pkg::OP_ADDIU, 5'd8, 5'd10, 16'hFFFD));
		store_result(enc_i(mips_pkg::OP_ANDI, 5'd9, 5'd10, 16'hF0F0));
		store_result(enc_i(mips_pkg::OP_ORI, 5'd8, 5'd10, 16'h1234));
		store_result(enc_i(mips_pkg::OP_XORI, 5'd9, 5'd10, 16'h8001));
		store_result(enc_i(mips_pkg::OP_SLTI, 5'd8, 5'd10, 16'hFF9C));
		store_result(enc_i(mips_pkg::OP_SLTIU, 5'd9, 5'd10, 16'h8000));
		store_result(enc_i(mips_pkg::OP_LUI, 5'd0, 5'd10, 16'hABCD));
		emit(enc_i(mips_pkg::OP_LW, 5'd16, 5'd11, 16'h0040)); // Reload first result
		emit(enc_r(mips_pkg::F_ADDU, 5'd2, 5'd11, 5'd2, 5'd0));
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd16, 5'd17, 16'h0100));
		emit(enc_i(mips_pkg::OP_SW, 5'd17, 5'd9, 16'hFFF8)); // Negative offset
		emit(enc_i(mips_pkg::OP_LW, 5'd17, 5'd13, 16'hFFF8));
		emit(enc_i(mips_pkg::OP_SW, 5'd16, 5'd13, 16'h0020));
		emit(enc_i(mips_pkg::OP_BEQ, 5'd8, 5'd8, 16'h0001)); // Taken
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0001));
		emit(enc_i(mips_pkg::OP_BNE, 5'd8, 5'd8, 16'h0001)); // Not taken
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0002));
		emit(enc_i(mips_pkg::OP_BNE, 5'd8, 5'd9, 16'h0001));
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0004));
		emit(enc_i(mips_pkg::OP_BEQ, 5'd8, 5'd9, 16'h0001));
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0008));
		emit(enc_j(mips_pkg::OP_J, base + 4 * (n + 2))); // Skip one word
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0010));
		emit(enc_j(mips_pkg::OP_JAL, base + 4 * (n + 4)));
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0020)); // Behind the PC+8 link
		emit(enc_r(mips_pkg::F_ADDU, 5'd2, 5'd31, 5'd2, 5'd0));
		emit(enc_r(mips_pkg::F_JR, 5'd0, 5'd0, 5'd0, 5'd0)); // Halt
		emit(enc_i(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'h0055)); // Subroutine
		emit(enc_r(mips_pkg::F_JR, 5'd31, 5'd0, 5'd0, 5'd0));
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		clk_enable <= 1'b1;
		cycles = 0;
		@(posedge clk);
		while (active === 1'b1 && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (active !== 1'b0) begin
			$display("processor did not halt");
			timeouts++;
		end
		repeat (6) @(posedge clk); // Checker watches v0 stay put
		$display("checker errors %0d, timeouts %0d", checker_i.error_count, timeouts);
		if (checker_i.error_count == 0 && timeouts == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
